// ==== compile.f ====
+incdir+src
src/wiscPkg.sv
src/pipeReg.sv
src/decodeStage.sv
src/executeStage.sv
src/resultStage.sv
src/wiscCore.sv
verif/wiscCoreTb.sv

// ==== Bender.yml ====
package:
  name: wisc_core

export_include_dirs:
  - src

sources:
  - files:
      - src/wiscPkg.sv
      - src/pipeReg.sv
      - src/decodeStage.sv
      - src/executeStage.sv
      - src/resultStage.sv
      - src/wiscCore.sv
  - target: test
    files:
      - verif/wiscCoreTb.sv

// ==== verif/wiscCoreTb.sv ====
//##########################################################
// WISC core testbench
// Drives instructions through decode, execute and result,
// keeps a register and memory model and checks every
// writeback against it, including stall and halt cases
//##########################################################

`timescale 1ns/10ps
`include "wisc_cfg.svh"

module wiscCoreTb;
   import wiscPkg::*;

   localparam int numLbi      = 8;
   localparam int numAlu      = 24;
   localparam int numImm      = 8;
   localparam int numMem      = 6;
   localparam int maxStall    = 8;
   localparam int addrW       = $clog2(`WISC_DMEM_DEPTH);
   localparam int instBudget  = numLbi + numAlu + 2 * numImm + 4 * numMem + 16;
   localparam int limitCycles = instBudget * 4 + 2 * maxStall + 64;

   typedef struct packed {
      regIdxT      wrtReg;
      dataT        data;
      logic [31:0] due;                        // edge count while the writeback is visible
   } expT;

   logic                    clk = 1'b0;
   logic                    rst;
   logic [`WISC_DATA_W-1:0] inst;
   logic                    instValid;
   logic                    stall;
   wbT                      wb;
   logic                    halted;

   dataT        modelRegs [`WISC_REG_CNT];
   dataT        modelMem [`WISC_DMEM_DEPTH];
   logic        modelHalted = 1'b0;
   expT         expQ [$];
   expT         head;
   int          edgeCnt = 0;
   logic [15:0] lfsr = 16'd14;
   string       testName = "reset";

   wiscCore uut (
      .clk(clk), .rst(rst), .inst(inst), .instValid(instValid),
      .stall(stall), .wb(wb), .halted(halted)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      edgeCnt <= edgeCnt + 1;
   end

   //##########################################################
   // failure reporting and random numbers
   //##########################################################
   task automatic abortRun(input string msg);
      $display("%s: %s", testName, msg);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic reportMismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
      $display("FAIL %s %s expected 0x%0h actual 0x%0h", testName, what, exp, act);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   // fibonacci lfsr with taps 16 14 13 11 stepped once per bit taken
   function automatic logic [15:0] randBits(input int n);
      logic [15:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r    = {r[14:0], lfsr[15]};
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
      end
      return r;
   endfunction

   function automatic regIdxT randReg();
      return regIdxT'(randBits(3));
   endfunction

   function automatic logic [15:0] rtypeInst(input logic [1:0] func, input regIdxT rs,
                                             input regIdxT rt, input regIdxT rd);
      return {opRtype, rs, rt, rd, func};
   endfunction

   function automatic logic [15:0] immInst(input opcodeT op, input regIdxT rs,
                                           input regIdxT rd, input logic [4:0] imm);
      return {op, rs, rd, imm};
   endfunction

   function automatic logic [15:0] lbiInst(input regIdxT rd, input logic [7:0] imm);
      return {opLbi, rd, imm};
   endfunction

   //##########################################################
   // reference model that pushes the expected writeback at issue
   //##########################################################
   task automatic modelStep(input logic [15:0] word, input int extra);
      regIdxT rs;
      regIdxT rt;
      regIdxT dst;
      dataT   res;
      dataT   addrSum;
      logic   hasWb;
      rs      = word[10:8];
      rt      = word[7:5];
      dst     = rt;                            // addi and ld write the Rt field
      addrSum = modelRegs[rs] + {{11{word[4]}}, word[4:0]};
      res     = addrSum;
      hasWb   = 1'b1;
      case (word[15:11])
         opRtype: begin
            dst = word[4:2];
            case (word[1:0])
               2'b00: res = modelRegs[rs] + modelRegs[rt];
               2'b01: res = modelRegs[rs] - modelRegs[rt];
               2'b10: res = modelRegs[rs] ^ modelRegs[rt];
               default: res = modelRegs[rs] & modelRegs[rt];
            endcase
         end
         opAddi: res = addrSum;
         opLbi: begin
            dst = rs;
            res = {{8{word[7]}}, word[7:0]};
         end
         opLd: res = modelMem[addrSum[addrW-1:0]];
         opSt: begin
            hasWb = 1'b0;
            if (!modelHalted) modelMem[addrSum[addrW-1:0]] = modelRegs[rt];
         end
         opHalt: begin
            hasWb       = 1'b0;
            modelHalted = 1'b1;
         end
         default: hasWb = 1'b0;
      endcase
      if (hasWb && !modelHalted) begin
         modelRegs[dst] = res;
         expQ.push_back(expT'{wrtReg: dst, data: res, due: edgeCnt + 2 + extra});
      end
   endtask

   //##########################################################
   // stimulus tasks
   //##########################################################
   task automatic sendInst(input logic [15:0] word, input int extra);
      @(posedge clk);
      #2;
      inst      = word;
      instValid = 1'b1;
      modelStep(word, extra);
   endtask

   task automatic idle();
      @(posedge clk);
      #2;
      instValid = 1'b0;
   endtask

   task automatic issue(input logic [15:0] word);
      sendInst(word, 0);
      idle();
   endtask

   task automatic drain();
      while (expQ.size() != 0) @(posedge clk);
   endtask

   // first sits in x2m and second in d2x when the stall is raised
   task automatic stallPair(input logic [15:0] first, input logic [15:0] second);
      int cycles;
      cycles = randBits(3) + 1;
      sendInst(first, 0);
      sendInst(second, cycles);
      @(posedge clk);
      #2;
      instValid = 1'b0;
      stall     = 1'b1;
      repeat (cycles) @(posedge clk);
      #2;
      stall = 1'b0;
      drain();
   endtask

   //##########################################################
   // checks
   //##########################################################
   always @(negedge clk) begin
      if (!rst) begin
         assert (!$isunknown(wb.wbValid)) else abortRun("wbValid is unknown");
         if (expQ.size() != 0 && expQ[0].due == edgeCnt) begin
            assert (wb.wbValid === 1'b1) else reportMismatch("wbValid", 1, wb.wbValid);
         end
         if (wb.wbValid === 1'b1) begin
            assert (expQ.size() != 0) else abortRun("writeback appeared with none expected");
            head = expQ.pop_front();
            assert (head.due == edgeCnt) else reportMismatch("wb edge", head.due, edgeCnt);
            assert (wb.wrtReg == head.wrtReg)
               else reportMismatch("wrtReg", head.wrtReg, wb.wrtReg);
            assert (wb.data == head.data) else reportMismatch("data", head.data, wb.data);
         end
      end
   end

   assert property (@(posedge clk) disable iff (rst) $past(stall) |-> !wb.wbValid)
      else abortRun("writeback appeared while the stall was registered");

   assert property (@(posedge clk) disable iff (rst) halted |-> !wb.wbValid)
      else abortRun("writeback appeared after halt");

   assert property (@(posedge clk) disable iff (rst) $past(halted) |-> halted)
      else abortRun("halted dropped after it was set");

   initial begin
      #(limitCycles * 40);
      abortRun("watchdog expired before the tests finished");
   end

   //##########################################################
   // test sequence
   //##########################################################
   initial begin
      regIdxT     base;
      logic [4:0] off;
      int         h;
      rst       = 1'b1;
      inst      = '0;
      instValid = 1'b0;
      stall     = 1'b0;
      repeat (3) begin
         @(posedge clk);
         #1;
         assert (wb.wbValid === 1'b0 && halted === 1'b0)
            else abortRun("wbValid or halted not low during reset");
      end
      #1 rst = 1'b0;
      repeat (4) @(posedge clk);               // no writeback may appear while idle

      testName = "regAlu";
      for (int i = 0; i < numLbi; i++) begin
         issue(lbiInst(regIdxT'(i), 8'(randBits(8))));
      end
      for (int i = 0; i < numAlu; i++) begin
         issue(rtypeInst(2'(randBits(2)), randReg(), randReg(), randReg()));
      end
      drain();

      testName = "immediate";
      for (int i = 0; i < numImm; i++) begin
         issue(immInst(opAddi, randReg(), randReg(), {i[0], 4'(randBits(4))}));
         issue(lbiInst(randReg(), {~i[0], 7'(randBits(7))}));
      end
      drain();

      testName = "memory";
      for (int i = 0; i < numMem; i++) begin
         base = randReg();
         off  = 5'(randBits(5));
         issue(lbiInst(base, 8'(randBits(8))));
         issue(lbiInst(base ^ 3'd1, 8'(randBits(8))));
         issue(immInst(opSt, base, base ^ 3'd1, off));
         issue(immInst(opLd, base, base ^ 3'd2, off));
      end
      drain();

      testName = "stall";
      issue(lbiInst(3'd1, 8'(randBits(8))));   // store base
      issue(lbiInst(3'd2, 8'(randBits(8))));   // store data
      drain();
      stallPair(rtypeInst(2'(randBits(2)), randReg(), randReg(), 3'd6),
                lbiInst(3'd5, 8'(randBits(8))));
      off = 5'(randBits(5));
      stallPair(lbiInst(3'd7, 8'(randBits(8))), immInst(opSt, 3'd1, 3'd2, off));
      issue(immInst(opLd, 3'd1, 3'd3, off));
      drain();

      testName = "halt";
      sendInst({opHalt, 11'h000}, 0);
      h = edgeCnt;
      idle();
      while (edgeCnt != h + 2) @(negedge clk);
      assert (halted === 1'b0) else reportMismatch("halted", 0, halted);
      @(negedge clk);
      assert (halted === 1'b1) else reportMismatch("halted", 1, halted);
      issue(lbiInst(3'd4, 8'h5a));
      issue(immInst(opLd, 3'd1, 3'd3, off));  // its result must never show up
      repeat (6) @(posedge clk);
      assert (halted === 1'b1) else reportMismatch("halted", 1, halted);

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// ==== src/wiscCore.sv ====
//##########################################################
// WISC core top level
// Decode, two stage registers, execute and result wired
// into a three stage pipeline with writeback fed back
//##########################################################

`timescale 1ns/10ps
`include "wisc_cfg.svh"

module wiscCore (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`WISC_DATA_W-1:0] inst,
   input  logic                    instValid,
   input  logic                    stall,
   output wiscPkg::wbT             wb,
   output logic                    halted
);
   import wiscPkg::*;

   decodeOutT dec2x;
   decodeOutT d2x;
   execOutT   x2mIn;
   execOutT   x2m;

   decodeStage decode (
      .clk(clk), .rst(rst), .inst(inst), .instValid(instValid),
      .stall(stall), .wb(wb), .dec2x(dec2x)
   );

   pipeReg #(.payloadT(decodeOutT)) d2xReg (
      .clk(clk), .rst(rst), .stall(stall), .d(dec2x), .q(d2x)
   );

   executeStage execute (
      .d2x(d2x), .x2mIn(x2mIn)
   );

   // execute to memory register
   pipeReg #(.payloadT(execOutT)) x2mReg (
      .clk(clk), .rst(rst), .stall(stall), .d(x2mIn), .q(x2m)
   );

   resultStage result (
      .clk(clk), .rst(rst), .stall(stall), .x2m(x2m),
      .wb(wb), .halted(halted)
   );

endmodule

// ==== src/resultStage.sv ====
//##########################################################
// Result stage
// Data memory access and writeback select; writes are held
// off for a registered stall and after halt
//##########################################################

`timescale 1ns/10ps
`include "wisc_cfg.svh"

module resultStage (
   input  logic             clk,
   input  logic             rst,
   input  logic             stall,
   input  wiscPkg::execOutT x2m,
   output wiscPkg::wbT      wb,
   output logic             halted
);

   localparam int addrW = $clog2(`WISC_DMEM_DEPTH);

   logic [`WISC_DATA_W-1:0] dmem [`WISC_DMEM_DEPTH];
   logic [addrW-1:0]        memAddr;
   logic [`WISC_DATA_W-1:0] loadData;
   logic                    stallM;
   logic                    commit;

   // the instruction in this stage may change state only once
   assign commit   = x2m.valid & ~stallM & ~halted;
   assign memAddr  = x2m.aluOut[addrW-1:0];
   assign loadData = dmem[memAddr];

   //##########################################################
   // stall copy and halt flag
   //##########################################################
   always_ff @(posedge clk) begin
      if (rst) begin
         stallM <= 1'b0;
         halted <= 1'b0;
      end else begin
         stallM <= stall;                      // masks the instruction held in x2m
         if (commit && x2m.halt) begin
            halted <= 1'b1;                    // sticky until reset
         end
      end
   end

   //##########################################################
   // data memory
   //##########################################################
   always_ff @(posedge clk) begin
      if (commit && x2m.memWrt) begin
         dmem[memAddr] <= x2m.storeData;
      end
   end

   always_comb begin
      wb.wbValid = commit & x2m.regWrt;
      wb.wrtReg  = x2m.wrtReg;
      wb.data    = x2m.readEn ? loadData : x2m.aluOut;
   end

endmodule

// ==== src/executeStage.sv ====
//##########################################################
// Execute stage
// ALU for the register and immediate forms; for loads and
// stores the same adder forms the memory address
//##########################################################

`timescale 1ns/10ps

module executeStage (
   input  wiscPkg::decodeOutT d2x,
   output wiscPkg::execOutT   x2mIn
);
   import wiscPkg::*;

   dataT aluRes;

   //##########################################################
   // ALU
   //##########################################################
   always_comb begin
      case (d2x.aluOp)
         aluAdd: aluRes = d2x.opA + d2x.opB;   // also base plus offset for ld and st
         aluSub: aluRes = d2x.opA - d2x.opB;
         aluXor: aluRes = d2x.opA ^ d2x.opB;
         aluAnd: aluRes = d2x.opA & d2x.opB;
         default: aluRes = d2x.opA + d2x.opB;
      endcase
   end

   //##########################################################
   // payload for the execute to memory register
   //##########################################################
   always_comb begin
      x2mIn.valid     = d2x.valid;
      x2mIn.aluOut    = aluRes;
      x2mIn.storeData = d2x.storeData;         // store data rides alongside the address
      x2mIn.wrtReg    = d2x.wrtReg;
      x2mIn.regWrt    = d2x.regWrt;
      x2mIn.memWrt    = d2x.memWrt;
      x2mIn.readEn    = d2x.readEn;
      x2mIn.halt      = d2x.halt;
   end

endmodule

// ==== src/decodeStage.sv ====
//##########################################################
// Decode stage
// Splits the instruction into fields, extends immediates,
// reads Rs and Rt from the register file and builds the
// control bits for execute and result
//##########################################################

`timescale 1ns/10ps
`include "wisc_cfg.svh"

module decodeStage (
   input  logic                    clk,
   input  logic                    rst,
   input  logic [`WISC_DATA_W-1:0] inst,
   input  logic                    instValid,
   input  logic                    stall,
   input  wiscPkg::wbT             wb,
   output wiscPkg::decodeOutT      dec2x
);
   import wiscPkg::*;

   dataT   regFile [`WISC_REG_CNT];
   opcodeT opcode;
   regIdxT rsIdx;
   regIdxT rtIdx;
   regIdxT rdIdx;
   dataT   rsVal;
   dataT   rtVal;
   dataT   imm5Ext;
   dataT   imm8Ext;

   assign opcode  = opcodeT'(inst[15:11]);
   assign rsIdx   = inst[10:8];
   assign rtIdx   = inst[7:5];
   assign rdIdx   = inst[4:2];
   assign imm5Ext = {{(`WISC_DATA_W-5){inst[4]}}, inst[4:0]};
   assign imm8Ext = {{(`WISC_DATA_W-8){inst[7]}}, inst[7:0]};

   //##########################################################
   // register file, written from result at the clock edge
   //##########################################################
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < `WISC_REG_CNT; i++) begin
            regFile[i] <= '0;
         end
      end else if (wb.wbValid) begin
         regFile[wb.wrtReg] <= wb.data;
      end
   end

   // a write landing this cycle is seen by the read straight away
   assign rsVal = (wb.wbValid && wb.wrtReg == rsIdx) ? wb.data : regFile[rsIdx];
   assign rtVal = (wb.wbValid && wb.wrtReg == rtIdx) ? wb.data : regFile[rtIdx];

   //##########################################################
   // control decode
   //##########################################################
   always_comb begin
      dec2x           = '0;
      dec2x.valid     = instValid & ~stall;    // offers during a stall are dropped
      dec2x.aluOp     = aluAdd;
      dec2x.opA       = rsVal;
      dec2x.opB       = imm5Ext;               // base plus offset unless changed below
      dec2x.storeData = rtVal;
      dec2x.wrtReg    = rtIdx;
      case (opcode)
         opRtype: begin
            dec2x.aluOp  = aluOpT'(inst[1:0]);
            dec2x.opB    = rtVal;
            dec2x.wrtReg = rdIdx;
            dec2x.regWrt = 1'b1;
         end
         opAddi: dec2x.regWrt = 1'b1;
         opLd: begin
            dec2x.regWrt = 1'b1;
            dec2x.readEn = 1'b1;
         end
         opSt: dec2x.memWrt = 1'b1;
         opLbi: begin
            dec2x.opA    = '0;                 // zero plus immediate loads it as is
            dec2x.opB    = imm8Ext;
            dec2x.wrtReg = rsIdx;
            dec2x.regWrt = 1'b1;
         end
         opHalt: dec2x.halt = 1'b1;
         default: ;                            // nop and unused opcodes do nothing
      endcase
   end

endmodule

// ==== src/pipeReg.sv ====
//##########################################################
// Pipeline stage register
// Holds one stage payload of any packed type, keeps it
// while stalled and clears it on reset
//##########################################################

`timescale 1ns/10ps

module pipeReg #(
   parameter type payloadT = logic
) (
   input  logic    clk,
   input  logic    rst,
   input  logic    stall,
   input  payloadT d,
   output payloadT q
);

   // the clock stays free running, stall only holds the contents
   always_ff @(posedge clk) begin
      if (rst) begin
         q <= '0;                              // drops the valid bit of the stage
      end else if (!stall) begin
         q <= d;
      end
   end

endmodule

// ==== src/wiscPkg.sv ====
//##########################################################
// WISC package
// Opcode and ALU encodings plus the payload structs that
// travel between decode, execute and result
//##########################################################

`include "wisc_cfg.svh"

package wiscPkg;

   typedef logic [`WISC_DATA_W-1:0]          dataT;
   typedef logic [$clog2(`WISC_REG_CNT)-1:0] regIdxT;

   //##########################################################
   // instruction encodings, opcode in bits 15 to 11
   //   rtype : Rs 10:8, Rt 7:5, Rd 4:2, func 1:0
   //   addi, ld, st : Rs 10:8, Rd 7:5, imm5 4:0
   //   lbi : Rd 10:8, imm8 7:0
   //##########################################################
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opAddi  = 5'b01000,
      opSt    = 5'b10000,                      // Rd field names the data register
      opLd    = 5'b10001,
      opLbi   = 5'b11000,
      opRtype = 5'b11011                       // func field selects the ALU operation
   } opcodeT;

   typedef enum logic [1:0] {
      aluAdd = 2'b00,
      aluSub = 2'b01,                          // opA minus opB, i.e. Rs minus Rt
      aluXor = 2'b10,
      aluAnd = 2'b11
   } aluOpT;

   typedef struct packed {
      logic   valid;
      aluOpT  aluOp;
      dataT   opA;
      dataT   opB;                             // Rt value or extended immediate
      dataT   storeData;
      regIdxT wrtReg;
      logic   regWrt;
      logic   memWrt;
      logic   readEn;
      logic   halt;
   } decodeOutT;

   typedef struct packed {
      logic   valid;
      dataT   aluOut;                          // result, or the address for ld and st
      dataT   storeData;
      regIdxT wrtReg;
      logic   regWrt;
      logic   memWrt;
      logic   readEn;
      logic   halt;
   } execOutT;

   typedef struct packed {
      logic   wbValid;
      regIdxT wrtReg;
      dataT   data;
   } wbT;

endpackage

// ==== src/wisc_cfg.svh ====
//##########################################################
// WISC core configuration
// Word width, register file size and data memory depth of
// the three-stage teaching pipeline
//##########################################################

`ifndef WISC_CFG_SVH
`define WISC_CFG_SVH

// data path and instruction word width
`define WISC_DATA_W 16

// register file entries, indexes are log2 of this wide
`define WISC_REG_CNT 8

`define WISC_DMEM_DEPTH 64  // data memory words, addressed by low address bits

`endif
